/* source/conv_mem_pkg.sv */
// memory package for the binary conv engine, word and address types plus the memory map
package conv_mem_pkg;

	// input, weight and output memories all share one address width
	typedef logic [11:0] mem_addr_t;

	// every memory word is 16 bits
	typedef logic [15:0] mem_data_t;

	// one input-memory word, decoded two ways
	// header words carry a row or column count
	// row words carry one pixel per column, bit c is column c
	typedef union packed {
		mem_data_t count;
		logic [15:0] pix;
	} in_word_u;

	// row count that marks the end of the matrix list
	localparam mem_data_t end_marker = 16'h00FF;

	// kernel bits live in weight word 1
	// word 0 holds the kernel size, always 3x3 here
	localparam mem_addr_t kernel_addr = 12'd1;

endpackage

/* source/conv_geom_pkg.sv */
// geometry package for the binary conv engine, kernel, window and count types
package conv_geom_pkg;

	// column index inside a row word, 0 to 15
	typedef logic [3:0] col_idx_t;

	// nine weight bits, bit 3*kr+kc is weight (kr,kc)
	typedef logic [8:0] kernel_t;

	// one window column, bit kr is row kr of the window
	typedef logic [2:0] tap_bits_t;

	// mismatch count over nine taps, 0 to 9
	typedef logic [3:0] mismatch_t;

	// up to 4 mismatches still means a positive sum
	// 9 taps of +1/-1, sum = 9 - 2*mismatches
	localparam mismatch_t sign_threshold = 4'd4;

endpackage

/* source/binconv_top.sv */
// binary 3x3 conv engine top, connects controller, correlator, tracker and packer
module binconv_top #(
	parameter conv_mem_pkg::mem_addr_t out_base_addr = 12'h000
) (
	input  logic clk,
	input  logic reset_b,
	input  logic dut_run,
	output logic dut_busy,
	output conv_mem_pkg::mem_addr_t dut_sram_read_address,
	input  conv_mem_pkg::mem_data_t sram_dut_read_data,
	output conv_mem_pkg::mem_addr_t dut_wmem_read_address,
	input  conv_mem_pkg::mem_data_t wmem_dut_read_data,
	output conv_mem_pkg::mem_addr_t dut_sram_write_address,
	output conv_mem_pkg::mem_data_t dut_sram_write_data,
	output logic dut_sram_write_enable
);

	// controller to correlator
	logic load_kernel;
	conv_geom_pkg::kernel_t kernel;
	conv_geom_pkg::tap_bits_t taps;

	// issue strobe, shared by correlator and tracker
	logic issue_valid;
	logic row_end;
	conv_geom_pkg::col_idx_t issue_col;
	conv_mem_pkg::mem_addr_t issue_waddr;

	// correlator results
	logic pix_valid;
	logic pix_bit;
	logic pipe_busy;
	logic pipe_empty;

	// tracker results, aligned with pix_valid
	conv_geom_pkg::col_idx_t pix_col;
	logic pix_in_range;
	logic pix_row_end;
	conv_mem_pkg::mem_addr_t pix_waddr;

	// controller holds the run until the pipe is drained
	assign pipe_empty = ~pipe_busy;

	sweep_controller #(
		.out_base_addr(out_base_addr)
	) sweep_controller_inst (
		.clk(clk),
		.reset_b(reset_b),
		.dut_run(dut_run),
		.dut_busy(dut_busy),
		.dut_sram_read_address(dut_sram_read_address),
		.dut_wmem_read_address(dut_wmem_read_address),
		.sram_dut_read_data(sram_dut_read_data),
		.wmem_dut_read_data(wmem_dut_read_data),
		.load_kernel(load_kernel),
		.kernel(kernel),
		.issue_valid(issue_valid),
		.taps(taps),
		.issue_col(issue_col),
		.row_end(row_end),
		.issue_waddr(issue_waddr),
		.pipe_empty(pipe_empty)
	);

	window_correlator window_correlator_inst (
		.clk(clk),
		.reset_b(reset_b),
		.load_kernel(load_kernel),
		.kernel(kernel),
		.issue_valid(issue_valid),
		.taps(taps),
		.row_end(row_end),
		.pix_valid(pix_valid),
		.pix_bit(pix_bit),
		.pipe_busy(pipe_busy)
	);

	position_tracker position_tracker_inst (
		.clk(clk),
		.reset_b(reset_b),
		.issue_valid(issue_valid),
		.issue_col(issue_col),
		.row_end(row_end),
		.issue_waddr(issue_waddr),
		.pix_col(pix_col),
		.pix_in_range(pix_in_range),
		.pix_row_end(pix_row_end),
		.pix_waddr(pix_waddr)
	);

	row_packer row_packer_inst (
		.clk(clk),
		.reset_b(reset_b),
		.pix_valid(pix_valid),
		.pix_bit(pix_bit),
		.pix_col(pix_col),
		.pix_in_range(pix_in_range),
		.pix_row_end(pix_row_end),
		.pix_waddr(pix_waddr),
		.dut_sram_write_address(dut_sram_write_address),
		.dut_sram_write_data(dut_sram_write_data),
		.dut_sram_write_enable(dut_sram_write_enable)
	);

endmodule

/* source/sweep_controller.sv */
// sweep controller, walks matrix headers and rows and issues one window column per cycle
module sweep_controller #(
	parameter conv_mem_pkg::mem_addr_t out_base_addr = '0
) (
	input  logic clk,
	input  logic reset_b,
	input  logic dut_run,
	output logic dut_busy,
	output conv_mem_pkg::mem_addr_t dut_sram_read_address,
	output conv_mem_pkg::mem_addr_t dut_wmem_read_address,
	input  conv_mem_pkg::mem_data_t sram_dut_read_data,
	input  conv_mem_pkg::mem_data_t wmem_dut_read_data,
	output logic load_kernel,
	output conv_geom_pkg::kernel_t kernel,
	output logic issue_valid,
	output conv_geom_pkg::tap_bits_t taps,
	output conv_geom_pkg::col_idx_t issue_col,
	output logic row_end,
	output conv_mem_pkg::mem_addr_t issue_waddr,
	input  logic pipe_empty
);
	import conv_mem_pkg::*;
	import conv_geom_pkg::*;

	// FSM encoding
	localparam logic [3:0] st_idle     = 4'd0;
	localparam logic [3:0] st_hdr_rows = 4'd1;
	localparam logic [3:0] st_hdr_cols = 4'd2;
	localparam logic [3:0] st_row0     = 4'd3;
	localparam logic [3:0] st_row1     = 4'd4;
	localparam logic [3:0] st_row2     = 4'd5;
	localparam logic [3:0] st_sweep    = 4'd6;
	localparam logic [3:0] st_next_row = 4'd7;
	localparam logic [3:0] st_drain    = 4'd8;

	logic [3:0] state;
	// read pointer, always the address on the bus
	mem_addr_t rd_addr;
	mem_addr_t waddr;
	// rows still to fetch after the first three
	logic [3:0] rows_left;
	col_idx_t last_col;
	col_idx_t col;
	// three-row band under the kernel
	mem_data_t row0;
	mem_data_t row1;
	mem_data_t row2;
	in_word_u rd_word;
	logic [3:0] rows_m3;
	col_idx_t cols_m1;

	// same read word, seen as a count or as pixels
	assign rd_word = sram_dut_read_data;
	// 16 wraps to 0 in four bits, so 16-3 and 16-1 still come out right
	assign rows_m3 = rd_word.count[3:0] - 4'd3;
	assign cols_m1 = rd_word.count[3:0] - 4'd1;

	assign dut_sram_read_address = rd_addr;
	// kernel word never moves
	assign dut_wmem_read_address = kernel_addr;
	assign load_kernel = (state == st_hdr_cols);
	assign kernel = wmem_dut_read_data[8:0];

	// column issue straight from the band registers
	assign issue_valid = (state == st_sweep);
	assign taps = {row2[col], row1[col], row0[col]};
	assign issue_col = col;
	assign row_end = issue_valid && (col == last_col);
	assign issue_waddr = waddr;

	always_ff @(posedge clk or negedge reset_b) begin
		if (!reset_b) begin
			state <= st_idle;
			dut_busy <= 1'b0;
			rd_addr <= '0;
			waddr <= '0;
			rows_left <= '0;
			last_col <= '0;
			col <= '0;
		end else begin
			case (state)
				st_idle: begin
					// address 0 is already on the bus
					if (dut_run) begin
						dut_busy <= 1'b1;
						rd_addr <= rd_addr + 12'd1;
						waddr <= out_base_addr;
						state <= st_hdr_rows;
					end
				end
				st_hdr_rows: begin
					if (rd_word.count == end_marker) begin
						state <= st_drain;
					end else begin
						rows_left <= rows_m3;
						rd_addr <= rd_addr + 12'd1;
						state <= st_hdr_cols;
					end
				end
				st_hdr_cols: begin
					last_col <= cols_m1;
					rd_addr <= rd_addr + 12'd1;
					state <= st_row0;
				end
				st_row0: begin
					rd_addr <= rd_addr + 12'd1;
					state <= st_row1;
				end
				st_row1: begin
					rd_addr <= rd_addr + 12'd1;
					state <= st_row2;
				end
				st_row2: begin
					// rd_addr now points at row 3 or the next header
					state <= st_sweep;
				end
				st_sweep: begin
					if (row_end) begin
						col <= '0;
						waddr <= waddr + 12'd1;
						if (rows_left != 4'd0) begin
							rows_left <= rows_left - 4'd1;
							state <= st_next_row;
						end else begin
							// next header was on the bus this cycle
							rd_addr <= rd_addr + 12'd1;
							state <= st_hdr_rows;
						end
					end else begin
						col <= col + 4'd1;
					end
				end
				st_next_row: begin
					rd_addr <= rd_addr + 12'd1;
					state <= st_sweep;
				end
				st_drain: begin
					// last write has to leave the packer first
					if (pipe_empty) begin
						dut_busy <= 1'b0;
						rd_addr <= '0;
						state <= st_idle;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	// band registers, shift up by one row per output row
	always_ff @(posedge clk) begin
		case (state)
			st_row0: row0 <= rd_word.pix;
			st_row1: row1 <= rd_word.pix;
			st_row2: row2 <= rd_word.pix;
			st_next_row: begin
				row0 <= row1;
				row1 <= row2;
				row2 <= rd_word.pix;
			end
			default: begin
				row0 <= row0;
			end
		endcase
	end

	// no column leaves once the run is over
	issue_in_run: assert property (@(posedge clk) disable iff (!reset_b)
		issue_valid |-> dut_busy);

endmodule

/* source/window_correlator.sv */
// window correlator, 3x3 binary window against the kernel with a two-stage mismatch count
module window_correlator (
	input  logic clk,
	input  logic reset_b,
	input  logic load_kernel,
	input  conv_geom_pkg::kernel_t kernel,
	input  logic issue_valid,
	input  conv_geom_pkg::tap_bits_t taps,
	input  logic row_end,
	output logic pix_valid,
	output logic pix_bit,
	output logic pipe_busy
);
	import conv_geom_pkg::*;

	kernel_t weights;
	// two older window columns, the live taps are the third
	tap_bits_t col_old;
	tap_bits_t col_mid;
	kernel_t win_flat;
	mismatch_t mism_now;
	mismatch_t mism_s1;
	logic s1_valid;

	always_ff @(posedge clk) begin
		if (load_kernel) begin
			weights <= kernel;
		end
	end

	// slide one column per issue, start fresh on each row
	always_ff @(posedge clk) begin
		if (issue_valid) begin
			if (row_end) begin
				col_old <= '0;
				col_mid <= '0;
			end else begin
				col_old <= col_mid;
				col_mid <= taps;
			end
		end
	end

	// flatten to kernel order, bit 3*kr+kc
	always_comb begin
		for (int kr = 0; kr < 3; kr++) begin
			win_flat[3*kr] = col_old[kr];
			win_flat[3*kr+1] = col_mid[kr];
			win_flat[3*kr+2] = taps[kr];
		end
	end

	// xor marks a -1 product
	always_comb begin
		mism_now = '0;
		for (int k = 0; k < 9; k++) begin
			mism_now = mism_now + {3'b000, win_flat[k] ^ weights[k]};
		end
	end

	always_ff @(posedge clk or negedge reset_b) begin
		if (!reset_b) begin
			s1_valid <= 1'b0;
			pix_valid <= 1'b0;
		end else begin
			s1_valid <= issue_valid;
			pix_valid <= s1_valid;
		end
	end

	// stage 1 count, stage 2 sign
	always_ff @(posedge clk) begin
		mism_s1 <= mism_now;
		pix_bit <= (mism_s1 <= sign_threshold);
	end

	assign pipe_busy = s1_valid | pix_valid;

	// kernel only reloads between sweeps
	kernel_stable: assert property (@(posedge clk) disable iff (!reset_b)
		!(load_kernel && issue_valid));

endmodule

/* source/position_tracker.sv */
// position tracker, carries column, row end and write address beside the correlator
module position_tracker (
	input  logic clk,
	input  logic reset_b,
	input  logic issue_valid,
	input  conv_geom_pkg::col_idx_t issue_col,
	input  logic row_end,
	input  conv_mem_pkg::mem_addr_t issue_waddr,
	output conv_geom_pkg::col_idx_t pix_col,
	output logic pix_in_range,
	output logic pix_row_end,
	output conv_mem_pkg::mem_addr_t pix_waddr
);
	import conv_mem_pkg::*;
	import conv_geom_pkg::*;

	col_idx_t col_s1;
	mem_addr_t waddr_s1;
	logic in_s1;
	logic end_s1;

	// flags qualified by the issue strobe
	always_ff @(posedge clk or negedge reset_b) begin
		if (!reset_b) begin
			in_s1 <= 1'b0;
			end_s1 <= 1'b0;
			pix_in_range <= 1'b0;
			pix_row_end <= 1'b0;
		end else begin
			// window is full from the third column on
			in_s1 <= issue_valid && (issue_col >= col_idx_t'(2));
			end_s1 <= issue_valid && row_end;
			pix_in_range <= in_s1;
			pix_row_end <= end_s1;
		end
	end

	// output bit j sits two columns behind the newest tap
	always_ff @(posedge clk) begin
		col_s1 <= issue_col - col_idx_t'(2);
		waddr_s1 <= issue_waddr;
		pix_col <= col_s1;
		pix_waddr <= waddr_s1;
	end

endmodule

/* source/row_packer.sv */
// row packer, collects result bits into a row word and writes it to output memory
module row_packer (
	input  logic clk,
	input  logic reset_b,
	input  logic pix_valid,
	input  logic pix_bit,
	input  conv_geom_pkg::col_idx_t pix_col,
	input  logic pix_in_range,
	input  logic pix_row_end,
	input  conv_mem_pkg::mem_addr_t pix_waddr,
	output conv_mem_pkg::mem_addr_t dut_sram_write_address,
	output conv_mem_pkg::mem_data_t dut_sram_write_data,
	output logic dut_sram_write_enable
);
	import conv_mem_pkg::*;

	// bits above cols-3 are never set, so they stay 0
	mem_data_t acc;
	mem_data_t merged;
	logic row_done;

	assign row_done = pix_valid && pix_row_end;

	// current pixel folded in, so the last bit rides with the write
	always_comb begin
		merged = acc;
		if (pix_valid && pix_in_range) begin
			merged[pix_col] = pix_bit;
		end
	end

	always_ff @(posedge clk or negedge reset_b) begin
		if (!reset_b) begin
			acc <= '0;
			dut_sram_write_enable <= 1'b0;
		end else begin
			dut_sram_write_enable <= row_done;
			// next row may already be arriving
			if (row_done) begin
				acc <= '0;
			end else begin
				acc <= merged;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (row_done) begin
			dut_sram_write_data <= merged;
			dut_sram_write_address <= pix_waddr;
		end
	end

	// rows are at least three columns apart
	single_write: assert property (@(posedge clk) disable iff (!reset_b)
		dut_sram_write_enable |=> !dut_sram_write_enable);

endmodule

/* verification/binconv_tb.sv */
// testbench for the binary conv engine, memory models, stim file replay and write checks
module binconv_tb;
	timeunit 1ns;
	timeprecision 100ps;

	import conv_mem_pkg::*;

	// output words start here for every run
	localparam mem_addr_t out_base = 12'h100;

	logic clk = 1'b0;
	logic reset_b;
	logic dut_run;
	logic dut_busy;
	mem_addr_t dut_sram_read_address;
	mem_data_t sram_dut_read_data;
	mem_addr_t dut_wmem_read_address;
	mem_data_t wmem_dut_read_data;
	mem_addr_t dut_sram_write_address;
	mem_data_t dut_sram_write_data;
	logic dut_sram_write_enable;

	// input and weight memories, plus the raw stim words
	mem_data_t sram [0:4095];
	mem_data_t wmem [0:4095];
	mem_data_t stim [0:4095];

	// writes seen during the current run, in order
	mem_addr_t got_addr[$];
	mem_data_t got_data[$];

	int watch_cycles = 0;

	binconv_top #(
		.out_base_addr(out_base)
	) binconv_top_inst (
		.clk(clk),
		.reset_b(reset_b),
		.dut_run(dut_run),
		.dut_busy(dut_busy),
		.dut_sram_read_address(dut_sram_read_address),
		.sram_dut_read_data(sram_dut_read_data),
		.dut_wmem_read_address(dut_wmem_read_address),
		.wmem_dut_read_data(wmem_dut_read_data),
		.dut_sram_write_address(dut_sram_write_address),
		.dut_sram_write_data(dut_sram_write_data),
		.dut_sram_write_enable(dut_sram_write_enable)
	);

	// 4 ns period
	always #2 clk = ~clk;

	// one-cycle read latency on both memories
	// address taken mid-cycle, data driven just after the next rising edge
	initial begin
		mem_addr_t sram_addr_q;
		mem_addr_t wmem_addr_q;
		sram_dut_read_data = '0;
		wmem_dut_read_data = '0;
		forever begin
			@(negedge clk);
			sram_addr_q = dut_sram_read_address;
			wmem_addr_q = dut_wmem_read_address;
			@(posedge clk);
			#1;
			sram_dut_read_data = sram[sram_addr_q];
			wmem_dut_read_data = wmem[wmem_addr_q];
		end
	end

	// output memory, captures every write pulse
	always @(negedge clk) begin
		if (reset_b && dut_sram_write_enable) begin
			got_addr.push_back(dut_sram_write_address);
			got_data.push_back(dut_sram_write_data);
		end
	end

	task automatic report_failure(string line);
		$display("%s", line);
		$display("TESTBENCH FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_flag(string name, logic exp, logic act);
		if (act !== exp) begin
			report_failure($sformatf("CHECK FAILED %s expected %h got %h", name, exp, act));
		end
	endtask

	task automatic check_count(int exp, int act);
		if (act != exp) begin
			report_failure($sformatf("CHECK FAILED write count expected %h got %h", exp, act));
		end
	endtask

	task automatic check_write(mem_addr_t exp_addr, mem_data_t exp_data,
		mem_addr_t act_addr, mem_data_t act_data);
		if (act_addr !== exp_addr) begin
			report_failure($sformatf("CHECK FAILED dut_sram_write_address expected %h got %h",
				exp_addr, act_addr));
		end
		if (act_data !== exp_data) begin
			report_failure($sformatf("CHECK FAILED dut_sram_write_data expected %h got %h",
				exp_data, act_data));
		end
	endtask

	function automatic mem_data_t stim_at(int i);
		return stim[mem_addr_t'(i)];
	endfunction

	// cycle budget, rows*(cols+1) per matrix plus 20 per test
	function automatic int run_budget();
		int p;
		int q;
		int n;
		int e;
		int budget;
		budget = 13;
		p = 1;
		for (int t = 0; t < int'(stim_at(0)); t++) begin
			n = int'(stim_at(p));
			budget += 20;
			q = p + 1;
			// walk the headers up to the end marker
			while (stim_at(q) != end_marker && q < 4000) begin
				budget += int'(stim_at(q)) * (int'(stim_at(q + 1)) + 1);
				q += 2 + int'(stim_at(q));
			end
			e = int'(stim_at(p + n + 2));
			p += n + 3 + e;
		end
		return budget;
	endfunction

	// one test, p moves past its stim record
	task automatic run_test(inout int p);
		int n;
		int e;
		n = int'(stim_at(p));
		// fill patterns carry the full address
		for (int a = 0; a < 4096; a++) begin
			sram[mem_addr_t'(a)] = {4'h5, mem_addr_t'(a)};
			wmem[mem_addr_t'(a)] = {4'hC, ~mem_addr_t'(a)};
		end
		for (int i = 0; i < n; i++) begin
			sram[mem_addr_t'(i)] = stim_at(p + 1 + i);
		end
		wmem[kernel_addr] = stim_at(p + n + 1);
		e = int'(stim_at(p + n + 2));
		got_addr.delete();
		got_data.delete();

		// one-cycle start pulse
		@(posedge clk);
		#1 dut_run = 1'b1;
		@(posedge clk);
		#1 dut_run = 1'b0;
		@(negedge clk);
		check_flag("dut_busy", 1'b1, dut_busy);
		while (dut_busy) begin
			@(negedge clk);
		end

		// writes in order from the base, no gaps
		check_count(e, got_addr.size());
		for (int k = 0; k < e; k++) begin
			check_write(out_base + mem_addr_t'(k), stim_at(p + n + 3 + k),
				got_addr[k], got_data[k]);
		end
		p = p + n + 3 + e;
	endtask

	initial begin
		wait (watch_cycles > 0);
		#(watch_cycles * 4);
		report_failure("timeout: the run did not finish in the expected number of cycles");
	end

	initial begin
		int p;
		reset_b = 1'b0;
		dut_run = 1'b0;
		$readmemh("verification/binconv_stim.hex", stim);
		watch_cycles = run_budget();

		// reset held for three rising edges
		repeat (3) @(posedge clk);
		#1 reset_b = 1'b1;
		@(negedge clk);
		check_flag("dut_busy", 1'b0, dut_busy);
		check_flag("dut_sram_write_enable", 1'b0, dut_sram_write_enable);

		p = 1;
		for (int t = 0; t < int'(stim_at(0)); t++) begin
			run_test(p);
		end
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

/* filelist.f */
source/conv_mem_pkg.sv
source/conv_geom_pkg.sv
source/binconv_top.sv
source/sweep_controller.sv
source/window_correlator.sv
source/position_tracker.sv
source/row_packer.sv
verification/binconv_tb.sv

/* Makefile */
# verilator flow for the binary conv engine testbench

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module binconv_tb -f filelist.f

# the log decides pass or fail
run: build
	-./obj_dir/Vbinconv_tb > sim.log 2>&1
	cat sim.log
	grep -q "TESTBENCH PASSED" sim.log

lint:
	verilator --lint-only --timing --assert --top-module binconv_tb -f filelist.f

clean:
	rm -rf obj_dir sim.log

/* verification/binconv_stim.hex */
// binary conv engine stimulus, 16-bit hex words
// first word is the test count, then per test: input word count n, n input words,
// kernel word, expected write count e, e expected output words
0005
// end marker alone, busy pulses with no writes
0001
00FF
0000
0000
// 3x3, rows match the kernel, high row bits ignored
0006
0003 0003 FFF5 0002 0006 00FF
0195
0001
0001
// 4x4, zero kernel, windows of 4 and 5 mismatches
0007
0004 0004 000C 000F 0000 0003 00FF
0000
0002
0001 0002
// 16x16, alternating 5555 and AAAA rows
0013
0010 0010
5555 AAAA 5555 AAAA 5555 AAAA 5555 AAAA
5555 AAAA 5555 AAAA 5555 AAAA 5555 AAAA
00FF
0155
000E
1555 2AAA 1555 2AAA 1555 2AAA 1555
2AAA 1555 2AAA 1555 2AAA 1555 2AAA
// 3x5 then 4x3 in one run, addresses continue
000C
0003 0005 F01B 8012 0E0F
0004 0003 FFF7 0004 1230 0007
00FF
0007
0003
0004 0001 0000
